// ==== source/uart_pkg.sv ====
package uart_pkg;

  // frame layout, 8N1
  localparam int data_bits_lp = 8;
  localparam int bit_idx_w_lp = 3;

  // bit period counter, same width as the clks_per_bit port
  localparam int clk_cnt_w_lp = 16;

  // status vector seen by the host
  localparam int status_w_lp = 4;

  // bit positions in the status vector
  localparam int st_ready_lp     = 0;
  localparam int st_frame_err_lp = 1;
  localparam int st_overrun_lp   = 2;
  localparam int st_tx_done_lp   = 3;

  // transmitter states
  typedef enum logic [2:0] {
    idle,
    start,
    data,
    stop,
    cleanup
  } tx_state_e;

  // receiver states
  typedef enum logic [1:0] {
    rx_idle,
    rx_start,
    rx_data,
    rx_stop
  } rx_state_e;

endpackage

// ==== source/uart_rx_if.sv ====
interface uart_rx_if;

  // one-cycle pulse at the end of a frame
  logic                              valid;

  // received byte, meaningful with valid
  logic [uart_pkg::data_bits_lp-1:0] data;

  // stop bit sampled low, meaningful with valid
  logic                              frame_err;

  // receiver side
  modport rx_mp (
    output valid,
    output data,
    output frame_err
  );

  // status unit side
  modport st_mp (
    input valid,
    input data,
    input frame_err
  );

endinterface

// ==== source/uart_tx.sv ====
module uart_tx (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              i_tx_en,
  input  logic [uart_pkg::data_bits_lp-1:0] i_tx_byte,
  input  logic [uart_pkg::clk_cnt_w_lp-1:0] i_clks_per_bit,
  output logic                              o_tx_serial,
  output logic                              o_tx_busy,
  output logic                              o_tx_done
);

  uart_pkg::tx_state_e               state_q;
  logic [uart_pkg::clk_cnt_w_lp-1:0] clk_cnt_q;
  logic [uart_pkg::bit_idx_w_lp-1:0] bit_idx_q;
  logic [uart_pkg::data_bits_lp-1:0] shift_q;
  logic                              load;
  logic                              bit_end;

  // accept a new byte only while idle
  assign load = (state_q == uart_pkg::idle) && i_tx_en;

  // last cycle of the current bit period
  assign bit_end = (clk_cnt_q >= i_clks_per_bit - 1'b1);

  // data shifter, bit 0 is always the next bit to go out
  always_ff @(posedge clk_i)
  begin
    if (load)
    begin
      shift_q <= i_tx_byte;
    end
    else if (state_q == uart_pkg::data && bit_end)
    begin
      shift_q <= shift_q >> 1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_ni)
    begin
      state_q     <= uart_pkg::idle;
      clk_cnt_q   <= '0;
      bit_idx_q   <= '0;
      o_tx_serial <= 1'b1;
      o_tx_busy   <= 1'b0;
      o_tx_done   <= 1'b0;
    end
    else
    begin
      case (state_q)
        uart_pkg::idle:
        begin
          o_tx_serial <= 1'b1;
          clk_cnt_q   <= '0;
          bit_idx_q   <= '0;
          // line drops on the same edge that loads the byte
          if (load)
          begin
            o_tx_serial <= 1'b0;
            o_tx_busy   <= 1'b1;
            state_q     <= uart_pkg::start;
          end
        end

        uart_pkg::start:
        begin
          if (bit_end)
          begin
            clk_cnt_q   <= '0;
            o_tx_serial <= shift_q[0];
            state_q     <= uart_pkg::data;
          end
          else
          begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end

        uart_pkg::data:
        begin
          if (bit_end)
          begin
            clk_cnt_q <= '0;
            bit_idx_q <= bit_idx_q + 1'b1;
            // index wraps to zero after the last data bit
            if (&bit_idx_q)
            begin
              o_tx_serial <= 1'b1;
              state_q     <= uart_pkg::stop;
            end
            else
            begin
              // shifter moves on this same edge
              o_tx_serial <= shift_q[1];
            end
          end
          else
          begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end

        uart_pkg::stop:
        begin
          if (bit_end)
          begin
            clk_cnt_q <= '0;
            o_tx_done <= 1'b1;
            state_q   <= uart_pkg::cleanup;
          end
          else
          begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end

        uart_pkg::cleanup:
        begin
          // done is high for exactly this one cycle
          o_tx_done <= 1'b0;
          o_tx_busy <= 1'b0;
          state_q   <= uart_pkg::idle;
        end

        default:
        begin
          state_q <= uart_pkg::idle;
        end
      endcase
    end
  end

  // done is a pulse, never a level
  a_tx_done_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    o_tx_done |=> !o_tx_done)
    else $error("uart_tx: tx_done high for two cycles");

endmodule

// ==== source/uart_rx.sv ====
module uart_rx (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              i_rx_serial,
  input  logic [uart_pkg::clk_cnt_w_lp-1:0] i_clks_per_bit,
  uart_rx_if.rx_mp                          o_rx
);

  uart_pkg::rx_state_e               state_q;
  logic [uart_pkg::clk_cnt_w_lp-1:0] clk_cnt_q;
  logic [uart_pkg::bit_idx_w_lp-1:0] bit_idx_q;
  logic [uart_pkg::data_bits_lp-1:0] shift_q;
  logic                              rx_meta_q;
  logic                              rx_sync_q;
  logic                              rx_prev_q;
  logic                              valid_q;
  logic                              frame_err_q;
  logic                              fall_edge;
  logic                              mid_start;
  logic                              bit_end;

  // two flop synchronizer plus a delayed copy for edge detection
  always_ff @(posedge clk_i)
  begin
    if (!rst_ni)
    begin
      rx_meta_q <= 1'b1;
      rx_sync_q <= 1'b1;
      rx_prev_q <= 1'b1;
    end
    else
    begin
      rx_meta_q <= i_rx_serial;
      rx_sync_q <= rx_meta_q;
      rx_prev_q <= rx_sync_q;
    end
  end

  assign fall_edge = rx_prev_q && !rx_sync_q;

  // middle of the start bit
  assign mid_start = (clk_cnt_q >= (i_clks_per_bit >> 1));

  // one full period after the previous sample
  assign bit_end = (clk_cnt_q >= i_clks_per_bit - 1'b1);

  // data bits arrive LSB first
  always_ff @(posedge clk_i)
  begin
    if (state_q == uart_pkg::rx_data && bit_end)
    begin
      shift_q <= {rx_sync_q, shift_q[uart_pkg::data_bits_lp-1:1]};
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_ni)
    begin
      state_q     <= uart_pkg::rx_idle;
      clk_cnt_q   <= '0;
      bit_idx_q   <= '0;
      valid_q     <= 1'b0;
      frame_err_q <= 1'b0;
    end
    else
    begin
      valid_q <= 1'b0;
      case (state_q)
        uart_pkg::rx_idle:
        begin
          clk_cnt_q <= '0;
          bit_idx_q <= '0;
          if (fall_edge)
          begin
            state_q <= uart_pkg::rx_start;
          end
        end

        uart_pkg::rx_start:
        begin
          if (mid_start)
          begin
            clk_cnt_q <= '0;
            // still high at mid-bit means a glitch
            if (rx_sync_q)
            begin
              state_q <= uart_pkg::rx_idle;
            end
            else
            begin
              state_q <= uart_pkg::rx_data;
            end
          end
          else
          begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end

        uart_pkg::rx_data:
        begin
          if (bit_end)
          begin
            clk_cnt_q <= '0;
            bit_idx_q <= bit_idx_q + 1'b1;
            if (&bit_idx_q)
            begin
              state_q <= uart_pkg::rx_stop;
            end
          end
          else
          begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end

        uart_pkg::rx_stop:
        begin
          if (bit_end)
          begin
            clk_cnt_q   <= '0;
            valid_q     <= 1'b1;
            frame_err_q <= !rx_sync_q;
            state_q     <= uart_pkg::rx_idle;
          end
          else
          begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end

        default:
        begin
          state_q <= uart_pkg::rx_idle;
        end
      endcase
    end
  end

  assign o_rx.valid     = valid_q;
  assign o_rx.data      = shift_q;
  assign o_rx.frame_err = frame_err_q;

  // a frame is reported once
  a_rx_valid_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_q |=> !valid_q)
    else $error("uart_rx: valid high for two cycles");

endmodule

// ==== source/uart_status.sv ====
module uart_status (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  uart_rx_if.st_mp                          i_rx,
  input  logic                              i_tx_done,
  input  logic                              i_rd_strobe,
  output logic [uart_pkg::data_bits_lp-1:0] o_rx_byte,
  output logic [uart_pkg::status_w_lp-1:0]  o_status
);

  logic [uart_pkg::status_w_lp-1:0] status_q;
  logic [uart_pkg::status_w_lp-1:0] status_d;

  // sticky flags, read strobe clears, new events win for their own bit
  always_comb
  begin
    status_d = status_q;
    if (i_rd_strobe)
    begin
      status_d = '0;
    end

    if (i_rx.valid)
    begin
      status_d[uart_pkg::st_ready_lp] = 1'b1;
      // byte still unread and not being read now
      if (status_q[uart_pkg::st_ready_lp] && !i_rd_strobe)
      begin
        status_d[uart_pkg::st_overrun_lp] = 1'b1;
      end
      if (i_rx.frame_err)
      begin
        status_d[uart_pkg::st_frame_err_lp] = 1'b1;
      end
    end

    if (i_tx_done)
    begin
      status_d[uart_pkg::st_tx_done_lp] = 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_ni)
    begin
      status_q  <= '0;
      o_rx_byte <= '0;
    end
    else
    begin
      status_q <= status_d;
      // stored even on a framing error, overwritten on overrun
      if (i_rx.valid)
      begin
        o_rx_byte <= i_rx.data;
      end
    end
  end

  assign o_status = status_q;

  // overrun only exists on top of an unread byte
  a_overrun_needs_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    status_q[uart_pkg::st_overrun_lp] |-> status_q[uart_pkg::st_ready_lp])
    else $error("uart_status: overrun set while ready clear");

endmodule

// ==== source/uart_core.sv ====
module uart_core (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              i_tx_en,
  input  logic [uart_pkg::data_bits_lp-1:0] i_tx_byte,
  input  logic [uart_pkg::clk_cnt_w_lp-1:0] i_clks_per_bit,
  input  logic                              i_rx_serial,
  input  logic                              i_rd_strobe,
  output logic                              o_tx_serial,
  output logic                              o_tx_busy,
  output logic [uart_pkg::data_bits_lp-1:0] o_rx_byte,
  output logic [uart_pkg::status_w_lp-1:0]  o_status
);

  // transmit complete pulse into the status unit
  logic tx_done;

  // receiver to status unit
  uart_rx_if u_rx_bus ();

  uart_tx u_uart_tx (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .i_tx_en        (i_tx_en),
    .i_tx_byte      (i_tx_byte),
    .i_clks_per_bit (i_clks_per_bit),
    .o_tx_serial    (o_tx_serial),
    .o_tx_busy      (o_tx_busy),
    .o_tx_done      (tx_done)
  );

  uart_rx u_uart_rx (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .i_rx_serial    (i_rx_serial),
    .i_clks_per_bit (i_clks_per_bit),
    .o_rx           (u_rx_bus.rx_mp)
  );

  uart_status u_uart_status (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .i_rx        (u_rx_bus.st_mp),
    .i_tx_done   (tx_done),
    .i_rd_strobe (i_rd_strobe),
    .o_rx_byte   (o_rx_byte),
    .o_status    (o_status)
  );

endmodule

// ==== verification/uart_core_tb.sv ====
module uart_core_tb;
  timeunit 1ns;
  timeprecision 100ps;

  // upper bound in cycles for any single wait
  localparam int wait_limit_lp = 2000;

  logic                              clk_i = 1'b0;
  logic                              rst_ni;
  logic                              i_tx_en;
  logic [uart_pkg::data_bits_lp-1:0] i_tx_byte;
  logic [uart_pkg::clk_cnt_w_lp-1:0] i_clks_per_bit;
  logic                              i_rx_serial;
  logic                              i_rd_strobe;
  logic                              o_tx_serial;
  logic                              o_tx_busy;
  logic [uart_pkg::data_bits_lp-1:0] o_rx_byte;
  logic [uart_pkg::status_w_lp-1:0]  o_status;

  // receiver input comes from the transmitter or the bit driver
  logic loop_en;
  logic bit_line;

  int errors;
  int seed_val;

  assign i_rx_serial = loop_en ? o_tx_serial : bit_line;

  always #50 clk_i = ~clk_i;

  uart_core u_uart_core (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .i_tx_en        (i_tx_en),
    .i_tx_byte      (i_tx_byte),
    .i_clks_per_bit (i_clks_per_bit),
    .i_rx_serial    (i_rx_serial),
    .i_rd_strobe    (i_rd_strobe),
    .o_tx_serial    (o_tx_serial),
    .o_tx_busy      (o_tx_busy),
    .o_rx_byte      (o_rx_byte),
    .o_status       (o_status)
  );

  task automatic report_mismatch(input string test, input int expected, input int actual);
    $display("Mismatch in %s: expected %0h, actual %0h", test, expected, actual);
    errors++;
  endtask

  task automatic report_timeout(input string test, input string what);
    $display("Timeout in %s: %s did not happen within %0d cycles", test, what, wait_limit_lp);
    errors++;
  endtask

  task automatic set_period(input int p);
    @(posedge clk_i);
    i_clks_per_bit <= p[15:0];
  endtask

  // one-cycle enable with the byte
  task automatic start_tx(input logic [7:0] b);
    @(posedge clk_i);
    i_tx_byte <= b;
    i_tx_en   <= 1'b1;
    @(posedge clk_i);
    i_tx_en <= 1'b0;
  endtask

  task automatic pulse_read();
    @(posedge clk_i);
    i_rd_strobe <= 1'b1;
    @(posedge clk_i);
    i_rd_strobe <= 1'b0;
    @(negedge clk_i);
  endtask

  // start bit, data LSB first, then the given stop level
  task automatic drive_frame(input logic [7:0] b, input logic stop_bit);
    logic [9:0] frame;
    frame = {stop_bit, b, 1'b0};
    for (int i = 0; i < 10; i++)
    begin
      @(posedge clk_i);
      bit_line <= frame[i];
      repeat (i_clks_per_bit - 1) @(posedge clk_i);
    end
    @(posedge clk_i);
    bit_line <= 1'b1;
    repeat (2) @(posedge clk_i);
  endtask

  task automatic wait_status_bit(input string test, input int pos);
    int n;
    n = 0;
    @(negedge clk_i);
    while (!o_status[pos] && n < wait_limit_lp)
    begin
      @(negedge clk_i);
      n++;
    end
    if (!o_status[pos])
    begin
      report_timeout(test, "status flag");
    end
  endtask

  task automatic wait_tx_idle(input string test);
    int n;
    n = 0;
    @(negedge clk_i);
    while (o_tx_busy && n < wait_limit_lp)
    begin
      @(negedge clk_i);
      n++;
    end
    if (o_tx_busy)
    begin
      report_timeout(test, "end of transmit");
    end
  endtask

  task automatic reset_idle();
    @(negedge clk_i);
    if (o_tx_serial !== 1'b1)
    begin
      report_mismatch("reset_idle", 1, o_tx_serial);
    end
    if (o_tx_busy !== 1'b0)
    begin
      report_mismatch("reset_idle", 0, o_tx_busy);
    end
    if (o_status !== '0)
    begin
      report_mismatch("reset_idle", 0, o_status);
    end
    if (o_rx_byte !== '0)
    begin
      report_mismatch("reset_idle", 0, o_rx_byte);
    end
  endtask

  task automatic tx_frame();
    int p;
    int n;
    logic [7:0] b;
    logic [9:0] exp_bits;
    p = 8;
    b = 8'h4d;
    exp_bits = {1'b1, b, 1'b0};
    set_period(p);
    start_tx(b);
    n = 0;
    // first low cycle is cycle 0 of the start bit
    @(negedge clk_i);
    while (o_tx_serial && n < wait_limit_lp)
    begin
      @(negedge clk_i);
      n++;
    end
    if (o_tx_serial)
    begin
      report_timeout("tx_frame", "start bit");
    end
    else
    begin
      repeat (p / 2) @(negedge clk_i);
      // frame in progress, so busy must be up
      if (o_tx_busy !== 1'b1)
      begin
        report_mismatch("tx_frame", 1, o_tx_busy);
      end
      for (int k = 0; k < 10; k++)
      begin
        if (k > 0)
        begin
          repeat (p) @(negedge clk_i);
        end
        if (o_tx_serial !== exp_bits[k])
        begin
          report_mismatch("tx_frame", exp_bits[k], o_tx_serial);
        end
      end
    end
    wait_tx_idle("tx_frame");
    if (o_status[uart_pkg::st_tx_done_lp] !== 1'b1)
    begin
      report_mismatch("tx_frame", 1, o_status[uart_pkg::st_tx_done_lp]);
    end
    pulse_read();
  endtask

  task automatic rx_byte();
    set_period(8);
    drive_frame(8'ha7, 1'b1);
    wait_status_bit("rx_byte", uart_pkg::st_ready_lp);
    if (o_rx_byte !== 8'ha7)
    begin
      report_mismatch("rx_byte", 8'ha7, o_rx_byte);
    end
    if (o_status[uart_pkg::st_frame_err_lp] !== 1'b0)
    begin
      report_mismatch("rx_byte", 0, o_status[uart_pkg::st_frame_err_lp]);
    end
    pulse_read();
    if (o_status[uart_pkg::st_ready_lp] !== 1'b0)
    begin
      report_mismatch("rx_byte", 0, o_status[uart_pkg::st_ready_lp]);
    end
  endtask

  task automatic rx_frame_error();
    drive_frame(8'h3c, 1'b0);
    wait_status_bit("rx_frame_error", uart_pkg::st_ready_lp);
    if (o_status[uart_pkg::st_frame_err_lp] !== 1'b1)
    begin
      report_mismatch("rx_frame_error", 1, o_status[uart_pkg::st_frame_err_lp]);
    end
    if (o_rx_byte !== 8'h3c)
    begin
      report_mismatch("rx_frame_error", 8'h3c, o_rx_byte);
    end
    pulse_read();
  endtask

  task automatic rx_overrun();
    drive_frame(8'h5a, 1'b1);
    drive_frame(8'he1, 1'b1);
    wait_status_bit("rx_overrun", uart_pkg::st_overrun_lp);
    if (o_rx_byte !== 8'he1)
    begin
      report_mismatch("rx_overrun", 8'he1, o_rx_byte);
    end
    pulse_read();
    if (o_status !== '0)
    begin
      report_mismatch("rx_overrun", 0, o_status);
    end
  endtask

  task automatic loopback_random();
    int p;
    int rnd;
    logic [7:0] b;
    p = 4 + int'($urandom % 17);
    set_period(p);
    @(posedge clk_i);
    loop_en <= 1'b1;
    for (int i = 0; i < 6; i++)
    begin
      rnd = $urandom;
      b = rnd[7:0];
      start_tx(b);
      wait_status_bit("loopback_random", uart_pkg::st_ready_lp);
      if (o_rx_byte !== b)
      begin
        report_mismatch("loopback_random", b, o_rx_byte);
      end
      if (o_status[uart_pkg::st_frame_err_lp] || o_status[uart_pkg::st_overrun_lp])
      begin
        report_mismatch("loopback_random", 0, o_status);
      end
      wait_tx_idle("loopback_random");
      pulse_read();
    end
    @(posedge clk_i);
    loop_en <= 1'b0;
  endtask

  initial
  begin
    errors         = 0;
    seed_val       = $urandom(32'h31e6_3cd8);
    rst_ni         = 1'b0;
    i_tx_en        = 1'b0;
    i_tx_byte      = '0;
    i_clks_per_bit = 16'd8;
    i_rd_strobe    = 1'b0;
    loop_en        = 1'b0;
    bit_line       = 1'b1;
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;

    reset_idle();
    tx_frame();
    rx_byte();
    rx_frame_error();
    rx_overrun();
    loopback_random();

    $display("uart_core_tb: %0d errors", errors);
    if (errors == 0)
    begin
      $display("Testbench passed");
    end
    else
    begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
source/uart_pkg.sv
source/uart_rx_if.sv
source/uart_tx.sv
source/uart_rx.sv
source/uart_status.sv
source/uart_core.sv
verification/uart_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the uart_core testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f sim.f \
  --top-module uart_core_tb \
  --Mdir obj_dir \
  -o uart_core_tb_sim

./obj_dir/uart_core_tb_sim 2>&1 | tee sim.log

if grep -qx "Testbench passed" sim.log; then
  echo "result: pass"
  exit 0
else
  echo "result: fail"
  exit 1
fi
